//--- include/jbus_mon_defs.svh
`ifndef JBUS_MON_DEFS_SVH
`define JBUS_MON_DEFS_SVH

`define JBUS_AD_W       128
`define JBUS_ADP_W      4     // One parity bit per 32-bit slice of the bus.
`define JBUS_AGENTS     7
`define JBUS_TAGS       8
`define JBUS_TAG_W      3     // Tag sits in adtype bits 7 to 5.
`define JBUS_WR_BEATS   2     // Data beats that follow every write request.

// APB register offsets.
`define REG_STATUS      8'h00 // Idle in bit 0, outstanding count in bits 7 to 4.
`define REG_OUTSTANDING 8'h04
`define REG_PAR_ERR     8'h08
`define REG_PROTO_ERR   8'h0C
`define REG_TXN_CNT     8'h10
`define REG_AGENT_ERR   8'h14
`define REG_CTRL        8'h18 // Bit 0 enable, bit 1 clear on write.

`endif

//--- src/jbus_mon_pkg.sv
`include "jbus_mon_defs.svh"

package jbus_mon_pkg;

  // Bus command, taken from adtype bits 2 to 0.
  typedef enum logic [2:0] {
    IDLE    = 3'd0,
    RD_REQ  = 3'd1,
    WR_REQ  = 3'd2,
    WR_DATA = 3'd3,
    RD_RET  = 3'd4
  } jbus_cmd_e;

  typedef enum logic {
    MON_IDLE,
    MON_WDATA                                // Waiting for write data beats.
  } ctrl_state_e;

  typedef struct packed {
    logic [`JBUS_AD_W-1:0]   ad;
    logic [7:0]              adtype;
    logic [`JBUS_ADP_W-1:0]  adp;
    logic [`JBUS_AGENTS-1:0] err;
  } jbus_sample_t;

  typedef struct packed {
    logic                   valid;
    jbus_cmd_e              cmd;
    logic [`JBUS_TAG_W-1:0] tag;
    logic                   seq_err;         // Missing or stray write data beat.
    logic                   done;            // Write completed on this beat.
  } jbus_event_t;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // Codes 5 to 7 are not used on the bus and count as idle.
  function automatic jbus_cmd_e decode_cmd(input logic [7:0] adtype);
    case (adtype[2:0])
      3'd1:    return RD_REQ;
      3'd2:    return WR_REQ;
      3'd3:    return WR_DATA;
      3'd4:    return RD_RET;
      default: return IDLE;
    endcase
  endfunction

endpackage

//--- src/jbus_mon_ctrl.sv
`timescale 1ns/1ps
`include "jbus_mon_defs.svh"

module jbus_mon_ctrl (
  input  logic                       jbus_j_clk,
  input  logic                       rst_n,
  input  jbus_mon_pkg::jbus_sample_t sample,
  input  logic                       enable,
  input  logic                       clear,
  output jbus_mon_pkg::jbus_sample_t sample_q,
  output jbus_mon_pkg::jbus_event_t  evt,
  output logic                       in_wdata
);
  import jbus_mon_pkg::*;

  localparam int BEAT_W = $clog2(`JBUS_WR_BEATS + 1);

  ctrl_state_e       state;
  ctrl_state_e       state_n;
  logic [BEAT_W-1:0] beat;
  logic [BEAT_W-1:0] beat_n;
  jbus_cmd_e         cmd;
  logic              seq_err;
  logic              wr_done;

  // Registered bus sample feeds the decoder and the parity check.
  always_ff @(posedge jbus_j_clk) begin
    if (!rst_n) begin
      sample_q <= '0;
    end else begin
      sample_q <= sample;
    end
  end

  assign cmd = decode_cmd(sample_q.adtype);

  always_comb begin
    state_n = state;
    beat_n  = beat;
    seq_err = 1'b0;
    wr_done = 1'b0;
    if (state == MON_WDATA && cmd == WR_DATA) begin
      if (beat == BEAT_W'(`JBUS_WR_BEATS - 1)) begin
        state_n = MON_IDLE;                  // Last beat closes the write.
        beat_n  = '0;
        wr_done = 1'b1;
      end else begin
        beat_n = beat + 1'b1;
      end
    end else if (state == MON_IDLE || cmd != IDLE) begin
      // A broken write sequence is flagged, then the command starts afresh.
      seq_err = (state == MON_WDATA) || (cmd == WR_DATA);
      state_n = (cmd == WR_REQ) ? MON_WDATA : MON_IDLE;
      beat_n  = '0;
    end
  end

  always_ff @(posedge jbus_j_clk) begin
    if (!rst_n || clear) begin
      state    <= MON_IDLE;
      beat     <= '0;
      evt      <= '0;
      in_wdata <= 1'b0;
    end else begin
      in_wdata <= (state == MON_WDATA);      // Delayed to line up with the tracker mask.
      if (enable) begin
        state       <= state_n;
        beat        <= beat_n;
        evt.valid   <= 1'b1;
        evt.cmd     <= cmd;
        evt.tag     <= sample_q.adtype[7 -: `JBUS_TAG_W];
        evt.seq_err <= seq_err;
        evt.done    <= wr_done;
      end else begin
        evt <= '0;
      end
    end
  end

endmodule

//--- src/jbus_parity_check.sv
`timescale 1ns/1ps
`include "jbus_mon_defs.svh"

module jbus_parity_check (
  input  logic                       jbus_j_clk,
  input  logic                       rst_n,
  input  jbus_mon_pkg::jbus_sample_t sample_q,
  input  logic                       enable,
  output logic                       par_err
);
  import jbus_mon_pkg::*;

  localparam int SLICE_W = `JBUS_AD_W / `JBUS_ADP_W;

  logic [`JBUS_ADP_W-1:0] slice_bad;
  jbus_cmd_e              cmd;

  assign cmd = decode_cmd(sample_q.adtype);

  // Even parity: each slice together with its parity bit has an even count of ones.
  always_comb begin
    for (int i = 0; i < `JBUS_ADP_W; i++) begin
      slice_bad[i] = ^{sample_q.ad[i*SLICE_W +: SLICE_W], sample_q.adp[i]};
    end
  end

  always_ff @(posedge jbus_j_clk) begin
    if (!rst_n) begin
      par_err <= 1'b0;
    end else begin
      par_err <= enable && (cmd != IDLE) && (|slice_bad); // Idle cycles carry no data.
    end
  end

endmodule

//--- src/jbus_txn_tracker.sv
`timescale 1ns/1ps
`include "jbus_mon_defs.svh"

module jbus_txn_tracker (
  input  logic                      jbus_j_clk,
  input  logic                      rst_n,
  input  jbus_mon_pkg::jbus_event_t evt,
  input  logic                      clear,
  output logic [`JBUS_TAGS-1:0]     outstanding,
  output logic [3:0]                out_count,
  output logic                      tag_err,
  output logic                      ret_done
);
  import jbus_mon_pkg::*;

  logic [`JBUS_TAGS-1:0] mask_n;
  logic [3:0]            count_n;
  logic                  hit;

  assign hit = outstanding[evt.tag];

  // The pulses come straight from the event so that the counters update with the mask.
  always_comb begin
    mask_n   = outstanding;
    tag_err  = 1'b0;
    ret_done = 1'b0;
    if (evt.valid) begin
      case (evt.cmd)
        RD_REQ: begin
          if (hit) begin
            tag_err = 1'b1;                  // Tag reused before its return.
          end else begin
            mask_n[evt.tag] = 1'b1;
          end
        end
        RD_RET: begin
          if (hit) begin
            mask_n[evt.tag] = 1'b0;
            ret_done        = 1'b1;
          end else begin
            tag_err = 1'b1;                  // Return with no request behind it.
          end
        end
        default: mask_n = outstanding;
      endcase
    end
  end

  always_comb begin
    count_n = '0;
    for (int i = 0; i < `JBUS_TAGS; i++) begin
      count_n = count_n + 4'(mask_n[i]);
    end
  end

  always_ff @(posedge jbus_j_clk) begin
    if (!rst_n || clear) begin
      outstanding <= '0;
      out_count   <= '0;
    end else begin
      outstanding <= mask_n;
      out_count   <= count_n;
    end
  end

endmodule

//--- src/jbus_apb_regs.sv
`timescale 1ns/1ps
`include "jbus_mon_defs.svh"

module jbus_apb_regs (
  input  logic                      jbus_j_clk,
  input  logic                      rst_n,
  input  jbus_mon_pkg::apb_req_t    apb_req,
  output jbus_mon_pkg::apb_rsp_t    apb_rsp,
  input  jbus_mon_pkg::jbus_event_t evt,
  input  logic                      par_err,
  input  logic                      tag_err,
  input  logic                      ret_done,
  input  logic [`JBUS_TAGS-1:0]     outstanding,
  input  logic [3:0]                out_count,
  input  logic                      in_wdata,
  input  logic [`JBUS_AGENTS-1:0]   err_q,
  output logic                      enable,
  output logic                      clear
);

  logic [15:0]             par_cnt;
  logic [15:0]             proto_cnt;
  logic [15:0]             txn_cnt;
  logic [`JBUS_AGENTS-1:0] agent_err;
  logic                    access;
  logic                    wr_en;
  logic                    ctrl_wr;
  logic                    mapped;
  logic [1:0]              proto_inc;
  logic [1:0]              txn_inc;
  logic [31:0]             rdata;

  // Counters stick at all ones instead of wrapping.
  function automatic logic [15:0] sat_add(input logic [15:0] cnt, input logic [1:0] inc);
    logic [16:0] sum;
    sum = {1'b0, cnt} + 17'(inc);
    return sum[16] ? 16'hffff : sum[15:0];
  endfunction

  assign access  = apb_req.psel && apb_req.penable;
  assign wr_en   = access && apb_req.pwrite;
  assign ctrl_wr = wr_en && (apb_req.paddr == `REG_CTRL);

  // A cycle can hold both a sequence error and a tag error.
  assign proto_inc = 2'(evt.valid && evt.seq_err) + 2'(tag_err);
  assign txn_inc   = 2'(evt.valid && evt.done) + 2'(ret_done);

  always_comb begin
    rdata  = '0;
    mapped = 1'b1;
    case (apb_req.paddr)
      `REG_STATUS:      rdata = {24'd0, out_count, 3'd0, !in_wdata && !(|outstanding)};
      `REG_OUTSTANDING: rdata = 32'(outstanding);
      `REG_PAR_ERR:     rdata = {16'd0, par_cnt};
      `REG_PROTO_ERR:   rdata = {16'd0, proto_cnt};
      `REG_TXN_CNT:     rdata = {16'd0, txn_cnt};
      `REG_AGENT_ERR:   rdata = 32'(agent_err);
      `REG_CTRL:        rdata = {31'd0, enable};
      default:          mapped = 1'b0;
    endcase
    apb_rsp.prdata  = rdata;
    apb_rsp.pready  = 1'b1;                  // No wait states.
    apb_rsp.pslverr = access && !mapped;
  end

  always_ff @(posedge jbus_j_clk) begin
    if (!rst_n) begin
      enable    <= 1'b1;
      clear     <= 1'b0;
      par_cnt   <= '0;
      proto_cnt <= '0;
      txn_cnt   <= '0;
      agent_err <= '0;
    end else begin
      clear <= ctrl_wr && apb_req.pwdata[1]; // One-cycle pulse.
      if (ctrl_wr) begin
        enable <= apb_req.pwdata[0];
      end
      if (clear) begin
        par_cnt   <= '0;
        proto_cnt <= '0;
        txn_cnt   <= '0;
        agent_err <= '0;
      end else begin
        par_cnt   <= sat_add(par_cnt, {1'b0, par_err});
        proto_cnt <= sat_add(proto_cnt, proto_inc);
        txn_cnt   <= sat_add(txn_cnt, txn_inc);
        if (enable) begin
          agent_err <= agent_err | err_q;
        end
      end
    end
  end

endmodule

//--- src/jbus_mon_top.sv
`timescale 1ns/1ps
`include "jbus_mon_defs.svh"

module jbus_mon_top (
  input  logic                    jbus_j_clk,
  input  logic                    rst_n,
  input  logic [`JBUS_AD_W-1:0]   jbus_j_ad,
  input  logic [7:0]              jbus_j_adtype,
  input  logic [`JBUS_ADP_W-1:0]  jbus_j_adp,
  input  logic [`JBUS_AGENTS-1:0] jbus_j_err,
  input  jbus_mon_pkg::apb_req_t  apb_req,
  output jbus_mon_pkg::apb_rsp_t  apb_rsp,
  output logic                    bus_is_idle,
  output logic                    uncompleted_accesses
);
  import jbus_mon_pkg::*;

  jbus_sample_t          sample;
  jbus_sample_t          sample_q;
  jbus_event_t           evt;
  logic                  enable;
  logic                  clear;
  logic                  in_wdata;
  logic                  par_err;
  logic                  tag_err;
  logic                  ret_done;
  logic [`JBUS_TAGS-1:0] outstanding;
  logic [3:0]            out_count;

  assign sample = '{ad: jbus_j_ad, adtype: jbus_j_adtype, adp: jbus_j_adp, err: jbus_j_err};

  jbus_mon_ctrl u_jbus_mon_ctrl (
    .jbus_j_clk (jbus_j_clk),
    .rst_n      (rst_n),
    .sample     (sample),
    .enable     (enable),
    .clear      (clear),
    .sample_q   (sample_q),
    .evt        (evt),
    .in_wdata   (in_wdata)
  );

  jbus_parity_check u_jbus_parity_check (
    .jbus_j_clk (jbus_j_clk),
    .rst_n      (rst_n),
    .sample_q   (sample_q),
    .enable     (enable),
    .par_err    (par_err)
  );

  jbus_txn_tracker u_jbus_txn_tracker (
    .jbus_j_clk  (jbus_j_clk),
    .rst_n       (rst_n),
    .evt         (evt),
    .clear       (clear),
    .outstanding (outstanding),
    .out_count   (out_count),
    .tag_err     (tag_err),
    .ret_done    (ret_done)
  );

  jbus_apb_regs u_jbus_apb_regs (
    .jbus_j_clk  (jbus_j_clk),
    .rst_n       (rst_n),
    .apb_req     (apb_req),
    .apb_rsp     (apb_rsp),
    .evt         (evt),
    .par_err     (par_err),
    .tag_err     (tag_err),
    .ret_done    (ret_done),
    .outstanding (outstanding),
    .out_count   (out_count),
    .in_wdata    (in_wdata),
    .err_q       (sample_q.err),
    .enable      (enable),
    .clear       (clear)
  );

  assign uncompleted_accesses = |outstanding;
  assign bus_is_idle          = !in_wdata && !uncompleted_accesses; // No write open and no read pending.

endmodule

//--- sim/jbus_mon_tb.sv
`timescale 1ns/1ps
`include "jbus_mon_defs.svh"

module jbus_mon_tb;
  import jbus_mon_pkg::*;

  localparam int PIPE_CYCLES = 4;            // Sample, event and register stages plus margin.
  localparam int APB_TIMEOUT = 16;

  logic                    jbus_j_clk;
  logic                    rst_n;
  logic [`JBUS_AD_W-1:0]   jbus_j_ad;
  logic [7:0]              jbus_j_adtype;
  logic [`JBUS_ADP_W-1:0]  jbus_j_adp;
  logic [`JBUS_AGENTS-1:0] jbus_j_err;
  apb_req_t                apb_req;
  apb_rsp_t                apb_rsp;
  logic                    bus_is_idle;
  logic                    uncompleted_accesses;

  integer                  seed;
  string                   test_name;

  // Reference model state.
  logic [`JBUS_TAGS-1:0]   m_mask;
  logic [`JBUS_AGENTS-1:0] m_agent;
  int                      m_par;
  int                      m_proto;
  int                      m_txn;
  int                      m_beat;
  bit                      m_inw;
  bit                      m_en;

  jbus_mon_top u_jbus_mon_top (
    .jbus_j_clk           (jbus_j_clk),
    .rst_n                (rst_n),
    .jbus_j_ad            (jbus_j_ad),
    .jbus_j_adtype        (jbus_j_adtype),
    .jbus_j_adp           (jbus_j_adp),
    .jbus_j_err           (jbus_j_err),
    .apb_req              (apb_req),
    .apb_rsp              (apb_rsp),
    .bus_is_idle          (bus_is_idle),
    .uncompleted_accesses (uncompleted_accesses)
  );

  always #2 jbus_j_clk = ~jbus_j_clk;

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else
      stop_with_failure($sformatf("error: %s %s expected 0x%0h actual 0x%0h",
                                  test_name, what, exp, act));
  endtask

  function automatic int count_ones(input logic [`JBUS_TAGS-1:0] mask);
    int n;
    n = 0;
    for (int i = 0; i < `JBUS_TAGS; i++) begin
      n = n + mask[i];
    end
    return n;
  endfunction

  // Random start, then the next tag that is not outstanding.
  function automatic logic [2:0] free_tag();
    logic [2:0] t;
    t = $random(seed);
    for (int i = 0; i < `JBUS_TAGS; i++) begin
      if (m_mask[t]) begin
        t = t + 1'b1;
      end
    end
    return t;
  endfunction

  task automatic model_step(input jbus_cmd_e cmd, input logic [2:0] tag, input logic bad_par,
                            input logic [`JBUS_AGENTS-1:0] err);
    if (!m_en) return;
    m_agent = m_agent | err;
    if (cmd != IDLE && bad_par) m_par++;
    if (m_inw && cmd == WR_DATA) begin
      m_beat++;
      if (m_beat == `JBUS_WR_BEATS) begin
        m_inw = 0;                           // Second beat completes the write.
        m_txn++;
      end
    end else if (m_inw && cmd != IDLE) begin
      m_proto++;
      m_inw  = (cmd == WR_REQ);
      m_beat = 0;
    end else if (!m_inw) begin
      if (cmd == WR_DATA) m_proto++;
      m_inw  = (cmd == WR_REQ);
      m_beat = 0;
    end
    if (cmd == RD_REQ) begin
      if (m_mask[tag]) m_proto++;
      else m_mask[tag] = 1'b1;
    end else if (cmd == RD_RET) begin
      if (m_mask[tag]) begin
        m_mask[tag] = 1'b0;
        m_txn++;
      end else begin
        m_proto++;
      end
    end
  endtask

  task automatic model_clear();
    m_mask  = '0;
    m_agent = '0;
    m_par   = 0;
    m_proto = 0;
    m_txn   = 0;
    m_beat  = 0;
    m_inw   = 0;
  endtask

  // One bus cycle with random data and even parity; flip inverts chosen parity bits.
  task automatic bus_cycle(input jbus_cmd_e cmd, input logic [2:0] tag,
                           input logic [`JBUS_ADP_W-1:0] flip,
                           input logic [`JBUS_AGENTS-1:0] err);
    logic [`JBUS_AD_W-1:0]  data;
    logic [`JBUS_ADP_W-1:0] par;
    for (int i = 0; i < `JBUS_AD_W / 32; i++) begin
      data[i*32 +: 32] = $random(seed);
    end
    for (int i = 0; i < `JBUS_ADP_W; i++) begin
      par[i] = ^data[i*32 +: 32];
    end
    @(posedge jbus_j_clk);
    jbus_j_ad     <= data;
    jbus_j_adtype <= {tag, 2'b00, cmd};
    jbus_j_adp    <= par ^ flip;
    jbus_j_err    <= err;
    model_step(cmd, tag, |flip, err);
  endtask

  task automatic settle();
    repeat (PIPE_CYCLES) bus_cycle(IDLE, 3'd0, '0, '0);
  endtask

  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic slverr);
    int waited;
    waited = 0;
    @(posedge jbus_j_clk);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
    @(posedge jbus_j_clk);
    apb_req.penable <= 1'b1;
    @(negedge jbus_j_clk);
    while (!apb_rsp.pready) begin
      waited++;
      if (waited > APB_TIMEOUT) stop_with_failure("APB access never saw pready");
      @(negedge jbus_j_clk);
    end
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    @(posedge jbus_j_clk);
    apb_req <= '0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata);
    logic [31:0] rd;
    logic        slv;
    apb_access(1'b1, addr, wdata, rd, slv);
    check("write pslverr", 0, slv);
  endtask

  task automatic read_check(input string what, input logic [7:0] addr, input logic [31:0] exp);
    logic [31:0] rd;
    logic        slv;
    apb_access(1'b0, addr, '0, rd, slv);
    check({what, " pslverr"}, 0, slv);
    check(what, exp, rd);
  endtask

  task automatic check_all();
    logic exp_idle;
    exp_idle = !m_inw && (m_mask == '0);
    @(negedge jbus_j_clk);
    check("bus_is_idle", exp_idle, bus_is_idle);
    check("uncompleted_accesses", |m_mask, uncompleted_accesses);
    read_check("REG_STATUS", `REG_STATUS,
               {24'd0, 4'(count_ones(m_mask)), 3'd0, exp_idle});
    read_check("REG_OUTSTANDING", `REG_OUTSTANDING, 32'(m_mask));
    read_check("REG_PAR_ERR", `REG_PAR_ERR, 32'(m_par));
    read_check("REG_PROTO_ERR", `REG_PROTO_ERR, 32'(m_proto));
    read_check("REG_TXN_CNT", `REG_TXN_CNT, 32'(m_txn));
    read_check("REG_AGENT_ERR", `REG_AGENT_ERR, 32'(m_agent));
    read_check("REG_CTRL", `REG_CTRL, 32'(m_en));
  endtask

  initial begin
    logic [2:0]  tags [3];
    logic [2:0]  t;
    logic [2:0]  u;
    logic [31:0] rd;
    logic        slv;
    int          txn_before;
    int          agent;
    seed          = 32'h94fc_a3d5;
    jbus_j_clk    = 1'b0;
    rst_n         = 1'b0;
    jbus_j_ad     = '0;
    jbus_j_adtype = '0;
    jbus_j_adp    = '0;
    jbus_j_err    = '0;
    apb_req       = '0;
    m_en          = 1;
    model_clear();
    repeat (2) @(posedge jbus_j_clk);
    rst_n <= 1'b1;

    test_name = "reset";
    check_all();
    apb_access(1'b0, 8'h1C, '0, rd, slv);
    check("unmapped pslverr", 1, slv);

    test_name = "reads";
    for (int i = 0; i < 3; i++) begin
      tags[i] = free_tag();
      bus_cycle(RD_REQ, tags[i], '0, '0);
    end
    settle();
    check_all();
    txn_before = m_txn;
    for (int i = 0; i < 3; i++) begin
      bus_cycle(RD_RET, tags[i], '0, '0);
    end
    settle();
    check_all();
    read_check("REG_TXN_CNT rise", `REG_TXN_CNT, 32'(txn_before + 3));

    test_name = "writes";
    bus_cycle(WR_REQ, 3'd0, '0, '0);
    bus_cycle(WR_DATA, 3'd0, '0, '0);
    bus_cycle(IDLE, 3'd0, '0, '0);       // Gap between beats is legal.
    bus_cycle(WR_DATA, 3'd0, '0, '0);
    settle();
    check_all();
    t = free_tag();
    bus_cycle(WR_REQ, 3'd0, '0, '0);
    bus_cycle(RD_REQ, t, '0, '0);        // Cuts the write short.
    bus_cycle(RD_RET, t, '0, '0);
    bus_cycle(WR_DATA, 3'd0, '0, '0);    // Stray beat.
    settle();
    check_all();

    test_name = "tag errors";
    t = free_tag();
    bus_cycle(RD_REQ, t, '0, '0);
    bus_cycle(RD_REQ, t, '0, '0);
    settle();
    check_all();
    u = free_tag();
    bus_cycle(RD_RET, u, '0, '0);
    settle();
    check_all();
    bus_cycle(RD_RET, t, '0, '0);
    settle();
    check_all();

    test_name = "parity and agent errors";
    t = free_tag();
    bus_cycle(RD_REQ, t, 4'b0001 << ($random(seed) & 3), '0);
    bus_cycle(RD_RET, t, '0, '0);
    settle();
    check_all();
    bus_cycle(IDLE, 3'd0, 4'b0100, '0);
    settle();
    check_all();
    agent = $unsigned($random(seed)) % `JBUS_AGENTS;
    bus_cycle(IDLE, 3'd0, '0, 7'b1 << agent);
    settle();
    check_all();

    test_name = "control";
    t = free_tag();
    bus_cycle(RD_REQ, t, '0, '0);
    bus_cycle(WR_REQ, 3'd0, '0, '0);     // Leaves a write open across the clear.
    settle();
    check_all();
    apb_write(`REG_CTRL, 32'h3);
    model_clear();
    settle();
    check_all();
    apb_write(`REG_CTRL, 32'h0);
    m_en = 0;
    bus_cycle(RD_REQ, free_tag(), 4'b0010, 7'h7f);
    bus_cycle(WR_DATA, 3'd0, '0, '0);
    settle();
    check_all();
    apb_write(`REG_CTRL, 32'h1);
    m_en = 1;
    t = free_tag();
    bus_cycle(RD_REQ, t, '0, '0);
    bus_cycle(RD_RET, t, '0, 7'h01);
    settle();
    check_all();

    $display("No errors");
    $finish;
  end

endmodule

//--- sim.f
+incdir+include
src/jbus_mon_pkg.sv
src/jbus_mon_ctrl.sv
src/jbus_parity_check.sv
src/jbus_txn_tracker.sv
src/jbus_apb_regs.sv
src/jbus_mon_top.sv
sim/jbus_mon_tb.sv

//--- Bender.yml
package:
  name: jbus_mon

sources:
  - include_dirs:
      - include
    files:
      - src/jbus_mon_pkg.sv
      - src/jbus_mon_ctrl.sv
      - src/jbus_parity_check.sv
      - src/jbus_txn_tracker.sv
      - src/jbus_apb_regs.sv
      - src/jbus_mon_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/jbus_mon_tb.sv
